/* apb_cfg.sv */
/*
 * APB configuration registers for the bouncing square,
 * with the live position readable at REG_POS
 */
`default_nettype none
`timescale 1ns/1ps

module apb_cfg import gfx_pkg::*, reg_pkg::*; (
    input  wire logic              clk_100m,
    input  wire logic              rst_n,
    input  wire logic [APB_AW-1:0] paddr,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [APB_DW-1:0] pwdata,
    output logic      [APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output cfg_t                   cfg,
    input  wire cord_t             pos_x,
    input  wire cord_t             pos_y
);

    logic              wr_en;
    logic [APB_DW-1:0] rdata;

    assign wr_en   = psel && penable && pwrite;  // access phase
    assign pready  = 1'b1;                       // zero wait states
    assign pslverr = 1'b0;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= CFG_RESET;
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL:  cfg.enable <= pwdata[0];
                REG_SIZE:  cfg.size   <= pwdata[SIZE_W-1:0];
                REG_SPEED: cfg.speed  <= pwdata[SPEED_W-1:0];
                REG_COLOR: begin
                    cfg.fg_idx <= pwdata[COLOR_FG_LSB +: $bits(cidx_t)];
                    cfg.bg_idx <= pwdata[COLOR_BG_LSB +: $bits(cidx_t)];
                end
                default: ;  // REG_POS and holes ignore writes
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (paddr)
            REG_CTRL:  rdata[0]             = cfg.enable;
            REG_SIZE:  rdata[SIZE_W-1:0]    = cfg.size;
            REG_SPEED: rdata[SPEED_W-1:0]   = cfg.speed;
            REG_COLOR: begin
                rdata[COLOR_FG_LSB +: $bits(cidx_t)] = cfg.fg_idx;
                rdata[COLOR_BG_LSB +: $bits(cidx_t)] = cfg.bg_idx;
            end
            REG_POS:   rdata                = {pos_y, pos_x};
            default:   rdata                = '0;  // unmapped reads zero
        endcase
    end

    assign prdata = (psel && !pwrite) ? rdata : '0;

endmodule

`default_nettype wire

/* bounce_chk.sv */
/*
 * concurrent checks on framebuffer writes and the APB bus,
 * bound into framebuffer_db and apb_cfg
 */
`default_nettype none
`timescale 1ns/1ps

module bounce_chk import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 18
) (
    input wire logic  clk_100m,
    input wire logic  rst_n,
    input wire logic  we,
    input wire logic  busy,
    input wire cord_t x,
    input wire cord_t y,
    input wire logic  psel,
    input wire logic  penable,
    input wire logic  pslverr
);

    no_write_busy: assert property (@(posedge clk_100m) disable iff (!rst_n)
        we |-> !busy)
        else $error("pixel write strobe while framebuffer is clearing");

    write_in_bounds: assert property (@(posedge clk_100m) disable iff (!rst_n)
        (we && !busy) |-> (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT))
        else $error("pixel write outside the framebuffer at %0d,%0d", x, y);

    enable_after_setup: assert property (@(posedge clk_100m) disable iff (!rst_n)
        $rose(penable) |-> (psel && $past(psel)))
        else $error("penable raised without a psel setup cycle");

    no_slverr: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !pslverr)
        else $error("pslverr asserted");

endmodule

bind framebuffer_db bounce_chk #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) chk_fb (
    .clk_100m, .rst_n, .we(fb.we), .busy(fb.busy), .x(fb.x), .y(fb.y),
    .psel(1'b0), .penable(1'b0), .pslverr(1'b0)
);

bind apb_cfg bounce_chk chk_apb (
    .clk_100m, .rst_n, .we(1'b0), .busy(1'b0), .x(16'sd0), .y(16'sd0),
    .psel, .penable, .pslverr
);

`default_nettype wire

/* bounce_top.sv */
/*
 * bouncing square top level: timing, APB registers, draw engine
 * and double-buffered framebuffer
 */
`default_nettype none
`timescale 1ns/1ps

module bounce_top import gfx_pkg::*, reg_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 18,
    parameter int SCALE     = 2,
    parameter int H_ACTIVE  = 64,
    parameter int H_TOTAL   = 80,
    parameter int V_ACTIVE  = 36,
    parameter int V_TOTAL   = 44
) (
    input  wire logic              clk_100m,
    input  wire logic              rst_n,
    input  wire logic [APB_AW-1:0] paddr,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [APB_DW-1:0] pwdata,
    output logic      [APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   de,
    output chan_t                  red,
    output chan_t                  green,
    output chan_t                  blue
);

    cord_t      sx, sy;
    logic       hs_raw, vs_raw, de_raw;
    logic       frame;
    cfg_t       cfg;
    cord_t      pos_x, pos_y;
    logic [1:0] hs_d, vs_d, de_d;  // match the 2-cycle colour path

    fb_write_if fbw ();

    disp_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) timing0 (
        .clk_100m, .rst_n, .sx, .sy,
        .hsync(hs_raw), .vsync(vs_raw), .de(de_raw),
        .frame, .line()
    );

    apb_cfg regs0 (
        .clk_100m, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .cfg, .pos_x, .pos_y
    );

    square_anim #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) anim0 (
        .clk_100m, .rst_n, .frame, .cfg, .fb(fbw), .pos_x, .pos_y
    );

    framebuffer_db #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE)
    ) fb0 (
        .clk_100m, .rst_n, .frame, .de(de_raw), .sx, .sy,
        .bg_idx(cfg.bg_idx), .fb(fbw), .red, .green, .blue
    );

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            hs_d <= '0;
            vs_d <= '0;
            de_d <= '0;
        end else begin
            hs_d <= {hs_d[0], hs_raw};
            vs_d <= {vs_d[0], vs_raw};
            de_d <= {de_d[0], de_raw};
        end
    end

    assign hsync = hs_d[1];
    assign vsync = vs_d[1];
    assign de    = de_d[1];

endmodule

`default_nettype wire

/* build.f */
gfx_pkg.sv
reg_pkg.sv
fb_write_if.sv
disp_timing.sv
apb_cfg.sv
square_anim.sv
framebuffer_db.sv
bounce_top.sv
bounce_chk.sv
tb_bounce.sv

/* disp_timing.sv */
/*
 * display timing: pixel and line counters with sync, data enable,
 * frame and line pulses
 */
`default_nettype none
`timescale 1ns/1ps

module disp_timing import gfx_pkg::*; #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 80,
    parameter int V_ACTIVE = 36,
    parameter int V_TOTAL  = 44
) (
    input  wire logic clk_100m,
    input  wire logic rst_n,
    output cord_t     sx,
    output cord_t     sy,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame,
    output logic      line
);

    // porch and sync widths, small to suit the short blanking
    localparam int H_FP   = 4;
    localparam int H_SYNC = 8;
    localparam int V_FP   = 2;
    localparam int V_SYNC = 3;

    localparam cord_t HA_END = cord_t'(H_ACTIVE);
    localparam cord_t VA_END = cord_t'(V_ACTIVE);
    localparam cord_t HS_STA = cord_t'(H_ACTIVE + H_FP);
    localparam cord_t HS_END = cord_t'(H_ACTIVE + H_FP + H_SYNC);
    localparam cord_t VS_STA = cord_t'(V_ACTIVE + V_FP);
    localparam cord_t VS_END = cord_t'(V_ACTIVE + V_FP + V_SYNC);
    localparam cord_t H_LAST = cord_t'(H_TOTAL - 1);
    localparam cord_t V_LAST = cord_t'(V_TOTAL - 1);

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 16'sd1;  // wrap at frame end
        end else begin
            sx <= sx + 16'sd1;
        end
    end

    always_comb begin
        hsync = (sx >= HS_STA) && (sx < HS_END);
        vsync = (sy >= VS_STA) && (sy < VS_END);
        de    = (sx < HA_END) && (sy < VA_END);
        frame = (sx == '0) && (sy == '0);
        line  = (sx == '0);  // every line, including blanking
    end

endmodule

`default_nettype wire

/* fb_write_if.sv */
/*
 * pixel write channel from the draw engine into the framebuffer
 */
`default_nettype none
`timescale 1ns/1ps

interface fb_write_if import gfx_pkg::*; ();

    logic  we;      // write strobe, taken when busy is low
    cord_t x;
    cord_t y;
    cidx_t cidx;
    logic  wready;  // back buffer cleared and free
    logic  busy;    // clear in progress

    modport draw (output we, output x, output y, output cidx,
                  input wready, input busy);

    modport store (input we, input x, input y, input cidx,
                   output wready, output busy);

endinterface

`default_nettype wire

/* framebuffer_db.sv */
/*
 * double-buffered framebuffer: bank swap and clear at frame start,
 * scaled read-out through the palette
 */
`default_nettype none
`timescale 1ns/1ps

module framebuffer_db import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 18,
    parameter int SCALE     = 2
) (
    input  wire logic  clk_100m,
    input  wire logic  rst_n,
    input  wire logic  frame,
    input  wire logic  de,
    input  wire cord_t sx,
    input  wire cord_t sy,
    input  wire cidx_t bg_idx,
    fb_write_if.store  fb,
    output chan_t      red,
    output chan_t      green,
    output chan_t      blue
);

    localparam int            FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int            AW        = $clog2(FB_PIXELS);
    localparam logic [AW-1:0] LAST_ADDR = AW'(FB_PIXELS - 1);
    localparam cord_t         FBW       = cord_t'(FB_WIDTH);
    localparam cord_t         FBH       = cord_t'(FB_HEIGHT);
    localparam cord_t         SC        = cord_t'(SCALE);

    cidx_t         bank [2][FB_PIXELS];
    logic          front_sel;
    logic          back_sel;
    logic          rd_bank;
    logic          clearing;
    logic          ready;
    logic [AW-1:0] clr_addr;
    logic [AW-1:0] waddr;
    logic [AW-1:0] raddr;
    cidx_t         bg_l;      // clear colour for this frame
    cord_t         fx, fy;    // scaled read position
    cord_t         w_lin, r_lin;
    logic          w_ok, r_ok;
    logic          rd_ok;
    cidx_t         rd_cidx;
    rgb_t          pix;

    assign back_sel = ~front_sel;
    assign rd_bank  = front_sel ^ frame;  // new front already on the swap cycle

    assign fb.busy   = clearing;
    assign fb.wready = ready;

    // write side, clipped to the buffer
    assign w_ok  = fb.we && !clearing && (fb.x >= 0) && (fb.x < FBW)
                   && (fb.y >= 0) && (fb.y < FBH);
    assign w_lin = fb.y * FBW + fb.x;
    assign waddr = w_lin[AW-1:0];

    // read side
    assign fx    = sx / SC;
    assign fy    = sy / SC;
    assign r_ok  = de && (fx >= 0) && (fx < FBW) && (fy >= 0) && (fy < FBH);
    assign r_lin = fy * FBW + fx;
    assign raddr = r_ok ? r_lin[AW-1:0] : '0;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            front_sel <= 1'b0;
            clearing  <= 1'b0;
            ready     <= 1'b0;
            clr_addr  <= '0;
            rd_ok     <= 1'b0;
            pix       <= '0;
        end else begin
            if (frame) begin
                front_sel <= ~front_sel;
                clearing  <= 1'b1;
                ready     <= 1'b0;
                clr_addr  <= '0;
            end else if (clearing) begin
                if (clr_addr == LAST_ADDR) begin
                    clearing <= 1'b0;
                    ready    <= 1'b1;  // back bank free for drawing
                end else begin
                    clr_addr <= clr_addr + 1'b1;
                end
            end
            rd_ok <= r_ok;
            pix   <= rd_ok ? palette[rd_cidx] : '0;  // black in blanking
        end
    end

    always_ff @(posedge clk_100m) begin
        if (frame) bg_l <= bg_idx;
        if (clearing) begin
            bank[back_sel][clr_addr] <= bg_l;
        end else if (w_ok) begin
            bank[back_sel][waddr] <= fb.cidx;
        end
        rd_cidx <= bank[rd_bank][raddr];
    end

    assign red   = pix.red;
    assign green = pix.green;
    assign blue  = pix.blue;

endmodule

`default_nettype wire

/* gfx_pkg.sv */
/*
 * graphics types: coordinates, colour index and channels,
 * plus the fixed 16-colour palette
 */
`default_nettype none

package gfx_pkg;

    typedef logic signed [15:0] cord_t;  // screen or framebuffer coordinate
    typedef logic [3:0]         cidx_t;  // palette index
    typedef logic [7:0]         chan_t;  // one colour channel

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    // index 1 is dark blue, 11 is green
    localparam rgb_t palette [16] = '{
        24'h000000, 24'h1D2B53, 24'h7E2553, 24'h008751,
        24'hAB5236, 24'h5F574F, 24'hC2C3C7, 24'hFFF1E8,
        24'hFF004D, 24'hFFA300, 24'hFFEC27, 24'h00E436,
        24'h29ADFF, 24'h83769C, 24'hFF77A8, 24'hFFCCAA
    };

endpackage

`default_nettype wire

/* reg_pkg.sv */
/*
 * APB register map, field widths and the configuration struct
 */
`default_nettype none

package reg_pkg;

    import gfx_pkg::*;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] REG_CTRL  = 8'h00;  // bit 0 enable
    localparam logic [APB_AW-1:0] REG_SIZE  = 8'h04;
    localparam logic [APB_AW-1:0] REG_SPEED = 8'h08;
    localparam logic [APB_AW-1:0] REG_COLOR = 8'h0C;  // fg low nibble, bg high
    localparam logic [APB_AW-1:0] REG_POS   = 8'h10;  // read only, y:x

    localparam int SIZE_W       = 8;
    localparam int SPEED_W      = 8;
    localparam int COLOR_FG_LSB = 0;
    localparam int COLOR_BG_LSB = 4;

    typedef struct packed {
        logic               enable;
        logic [SIZE_W-1:0]  size;    // side in framebuffer pixels
        logic [SPEED_W-1:0] speed;   // pixels per frame
        cidx_t              fg_idx;
        cidx_t              bg_idx;
    } cfg_t;

    localparam cfg_t CFG_RESET = '{enable: 1'b0, size: 8'd8, speed: 8'd1,
                                   fg_idx: 4'd11, bg_idx: 4'd1};

endpackage

`default_nettype wire

/* square_anim.sv */
/*
 * bounce engine: moves the square once per frame, then fills it
 * row by row into the back buffer
 */
`default_nettype none
`timescale 1ns/1ps

module square_anim import gfx_pkg::*, reg_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 18
) (
    input  wire logic clk_100m,
    input  wire logic rst_n,
    input  wire logic frame,
    input  wire cfg_t cfg,
    fb_write_if.draw  fb,
    output cord_t     pos_x,
    output cord_t     pos_y
);

    localparam cord_t LIM_X = cord_t'(FB_WIDTH);
    localparam cord_t LIM_Y = cord_t'(FB_HEIGHT);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    logic              dir_x, dir_y;  // 1 is left or up
    logic              nxt_dir_x, nxt_dir_y;
    cord_t             nxt_x, nxt_y;
    cord_t             sz, spd;       // live config widened
    logic [SIZE_W-1:0] size_l;        // frozen at frame pulse
    cidx_t             fg_l;
    cord_t             x0, x1, y1;    // fill bounds, inclusive
    logic              last_col, last_row;

    // one axis of the bounce rule, returns the new direction
    function automatic logic bounce(input cord_t p, input logic d, input cord_t lim,
                                    input cord_t size, input cord_t s,
                                    output cord_t np);
        logic nd;
        if (p >= lim - (size + s)) begin
            nd = 1'b1;
            np = p - s;
        end else if (p < s) begin
            nd = 1'b0;
            np = p + s;
        end else begin
            nd = d;
            np = d ? p - s : p + s;
        end
        return nd;
    endfunction

    assign sz  = cord_t'(cfg.size);
    assign spd = cord_t'(cfg.speed);

    always_comb begin
        nxt_dir_x = bounce(pos_x, dir_x, LIM_X, sz, spd, nxt_x);
        nxt_dir_y = bounce(pos_y, dir_y, LIM_Y, sz, spd, nxt_y);
    end

    assign last_col = (fb.x == x1);
    assign last_row = (fb.y == y1);
    assign fb.we    = (state == DRAW);

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pos_x <= '0;
            pos_y <= '0;
            dir_x <= 1'b0;
            dir_y <= 1'b0;
        end else begin
            if (frame && cfg.enable) begin  // motion once per frame
                pos_x <= nxt_x;
                pos_y <= nxt_y;
                dir_x <= nxt_dir_x;
                dir_y <= nxt_dir_y;
            end
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: if (fb.wready) state <= (size_l == '0) ? DONE : DRAW;
                DRAW: if (!fb.busy && last_col && last_row) state <= DONE;
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // fill raster, advances only on accepted writes
    always_ff @(posedge clk_100m) begin
        if (frame) begin
            size_l <= cfg.size;
            fg_l   <= cfg.fg_idx;
        end
        if (state == INIT && fb.wready) begin
            fb.x    <= pos_x;
            fb.y    <= pos_y;
            fb.cidx <= fg_l;
            x0      <= pos_x;
            x1      <= pos_x + cord_t'(size_l) - 16'sd1;
            y1      <= pos_y + cord_t'(size_l) - 16'sd1;
        end else if (fb.we && !fb.busy) begin
            if (last_col) begin
                fb.x <= x0;
                fb.y <= fb.y + 16'sd1;
            end else begin
                fb.x <= fb.x + 16'sd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_bounce.sv */
/*
 * testbench for the bouncing square: APB setup, position sequence
 * and pixel comparison against a reference image
 */
`default_nettype none
`timescale 1ns/1ps

module tb_bounce import gfx_pkg::*, reg_pkg::*; ();

    localparam int FB_WIDTH      = 32;
    localparam int FB_HEIGHT     = 18;
    localparam int SCALE         = 2;
    localparam int H_TOTAL       = 80;
    localparam int V_TOTAL       = 44;
    localparam int EN_FRAMES     = 6;
    localparam int BOUNCE_FRAMES = 32;
    localparam int COLOR_FRAMES  = 5;
    localparam int TEST_FRAMES   = 5 + EN_FRAMES + BOUNCE_FRAMES + COLOR_FRAMES;
    localparam int WD_NS         = (TEST_FRAMES + 4) * H_TOTAL * V_TOTAL * 10;
    localparam int NEVER         = 32'h7fff_ffff;

    logic              clk_100m, rst_n, psel, penable, pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata, prdata, d;
    logic              pready, pslverr, hsync, vsync, de;
    chan_t             red, green, blue;

    logic [31:0] seed;
    cfg_t        exp_cfg;                 // size and speed for the reference
    cidx_t       fg_a, bg_a, fg_b, bg_b;  // colours before and after col_frame
    cidx_t       fg, bg;
    int          en_frame, chk_from, col_frame;
    int          vs_count, col, row, fpx, fpy, n;
    logic        vs_q, de_q;
    int          hs_count;                // hsync pulses since the last vsync
    logic        hs_q;
    int          last_x, last_y, dx_q, dy_q;
    logic        turn_r, turn_l, turn_b, turn_t;  // reversals seen per edge

    bounce_top #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE),
        .H_ACTIVE(64), .H_TOTAL(H_TOTAL), .V_ACTIVE(36), .V_TOTAL(V_TOTAL)
    ) dut0 (
        .clk_100m, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .hsync, .vsync, .de, .red, .green, .blue
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one axis after n frame updates, starting at 0 moving forward
    function automatic cord_t ref_axis(input int lim, input int size, input int s,
                                       input int n);
        int p;
        int i;
        bit back;
        p    = 0;
        back = 0;
        for (i = 0; i < n; i++) begin
            if (p >= lim - (size + s)) begin
                back = 1;
                p    = p - s;
            end else if (p < s) begin
                back = 0;
                p    = p + s;
            end else begin
                p = back ? p - s : p + s;
            end
        end
        return cord_t'(p);
    endfunction

    function automatic rgb_t ref_rgb(input int sx, input int sy, input int px,
                                     input int py, input int size,
                                     input cidx_t fgc, input cidx_t bgc);
        int fx;
        int fy;
        fx = sx / SCALE;
        fy = sy / SCALE;
        if (fx >= px && fx < px + size && fy >= py && fy < py + size)
            return palette[fgc];
        return palette[bgc];
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp)
            fail_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_pos(input string name, input cord_t exp, input cord_t act);
        if (act !== exp)
            fail_run($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_reg(input string name, input logic [APB_DW-1:0] exp,
                             input logic [APB_DW-1:0] act);
        if (act !== exp)
            fail_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            fail_run($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] a, input logic [APB_DW-1:0] v);
        @(negedge clk_100m);
        paddr  = a;
        pwdata = v;
        pwrite = 1'b1;
        psel   = 1'b1;
        @(negedge clk_100m);
        penable = 1'b1;
        @(negedge clk_100m);
        if (pready !== 1'b1)
            fail_run("pready was low during an APB write");
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] a, output logic [APB_DW-1:0] v);
        @(negedge clk_100m);
        paddr  = a;
        pwrite = 1'b0;
        psel   = 1'b1;
        @(negedge clk_100m);
        penable = 1'b1;
        @(negedge clk_100m);  // access edge has passed
        v       = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic next_frame();
        @(posedge vsync);
        repeat (2) @(negedge clk_100m);
    endtask

    // position read once per frame, plus reversal tracking
    task automatic check_position(input string name);
        logic [APB_DW-1:0] v;
        int                ex;
        int                ey;
        apb_read(REG_POS, v);
        ex = ref_axis(FB_WIDTH, exp_cfg.size, exp_cfg.speed, vs_count - en_frame);
        ey = ref_axis(FB_HEIGHT, exp_cfg.size, exp_cfg.speed, vs_count - en_frame);
        check_pos({name, " x"}, cord_t'(ex), cord_t'(v[15:0]));
        check_pos({name, " y"}, cord_t'(ey), cord_t'(v[31:16]));
        if (dx_q > 0 && ex < last_x) turn_r = 1'b1;
        if (dx_q < 0 && ex > last_x) turn_l = 1'b1;
        if (dy_q > 0 && ey < last_y) turn_b = 1'b1;
        if (dy_q < 0 && ey > last_y) turn_t = 1'b1;
        dx_q   = ex - last_x;
        dy_q   = ey - last_y;
        last_x = ex;
        last_y = ey;
    endtask

    // pixel compare, screen position rebuilt from the DUT's de and vsync
    always @(negedge clk_100m) begin
        if (!rst_n) begin
            vs_count = 0;
            col      = 0;
            row      = 0;
            vs_q     = 1'b0;
            de_q     = 1'b0;
            hs_count = 0;
            hs_q     = 1'b0;
        end else begin
            if (vsync && !vs_q) begin
                if (vs_count > 0)  // one hsync per line over a whole frame
                    check_count("hsync pulses per frame", V_TOTAL, hs_count);
                vs_count = vs_count + 1;
                row      = 0;
                hs_count = 0;
            end
            if (hsync && !hs_q)
                hs_count = hs_count + 1;
            if (de) begin
                if (col == 0 && row == 0) begin  // position shown in this frame
                    n   = vs_count - en_frame;
                    fpx = ref_axis(FB_WIDTH, exp_cfg.size, exp_cfg.speed, n);
                    fpy = ref_axis(FB_HEIGHT, exp_cfg.size, exp_cfg.speed, n);
                end
                if (vs_count >= chk_from) begin
                    fg = (vs_count >= col_frame) ? fg_b : fg_a;
                    bg = (vs_count >= col_frame) ? bg_b : bg_a;
                    check_rgb($sformatf("frame %0d pixel %0d,%0d", vs_count, col, row),
                              ref_rgb(col, row, fpx, fpy, exp_cfg.size, fg, bg),
                              {red, green, blue});
                end
                col = col + 1;
            end else begin
                check_rgb("blanking colour", '0, {red, green, blue});
                if (de_q) begin
                    col = 0;
                    row = row + 1;
                end
            end
            vs_q = vsync;
            de_q = de;
            hs_q = hsync;
        end
    end

    initial begin
        #(WD_NS);
        fail_run("timeout: the test sequence did not finish in time");
    end

    initial begin
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        seed      = 32'h82f0_9f1a;
        exp_cfg   = '{enable: 1'b0, size: 8'd8, speed: 8'd1, fg_idx: 4'd11, bg_idx: 4'd1};
        fg_a      = 4'd11;
        bg_a      = 4'd1;
        fg_b      = 4'd11;
        bg_b      = 4'd1;
        en_frame  = 0;
        chk_from  = NEVER;
        col_frame = NEVER;
        {last_x, last_y, dx_q, dy_q} = '0;
        {turn_r, turn_l, turn_b, turn_t} = '0;
        repeat (5) @(negedge clk_100m);
        rst_n = 1'b1;

        // reset values, unmapped offsets, no motion while disabled
        apb_read(REG_CTRL, d);
        check_reg("reset ctrl", 32'h0, d);
        apb_read(REG_SIZE, d);
        check_reg("reset size", 32'd8, d);
        apb_read(REG_SPEED, d);
        check_reg("reset speed", 32'd1, d);
        apb_read(REG_COLOR, d);
        check_reg("reset colour", 32'h1B, d);
        apb_read(REG_POS, d);
        check_reg("reset position", 32'h0, d);
        apb_read(8'h14, d);
        check_reg("unmapped 0x14", 32'h0, d);
        apb_read(8'h3C, d);
        check_reg("unmapped 0x3c", 32'h0, d);
        next_frame();
        next_frame();
        apb_read(REG_POS, d);
        check_reg("position while disabled", 32'h0, d);

        // default settings with enable
        next_frame();
        en_frame = vs_count;
        chk_from = en_frame + 2;
        apb_write(REG_CTRL, 32'h1);
        repeat (EN_FRAMES) begin
            next_frame();
            check_position("default");
        end

        // fresh start, random size, speed and colours
        chk_from = NEVER;
        @(negedge clk_100m);
        rst_n = 1'b0;
        repeat (5) @(negedge clk_100m);
        rst_n = 1'b1;
        seed          = lcg_next(seed);
        exp_cfg.size  = 8'(4 + seed[23:16] % 5);
        seed          = lcg_next(seed);
        exp_cfg.speed = 8'(2 + seed[23:16] % 3);
        seed          = lcg_next(seed);
        fg_a          = seed[19:16];
        bg_a          = fg_a + 4'(1 + seed[27:24] % 15);  // never equal to fg
        {last_x, last_y, dx_q, dy_q} = '0;
        next_frame();
        apb_write(REG_SIZE, 32'(exp_cfg.size));
        apb_write(REG_SPEED, 32'(exp_cfg.speed));
        apb_write(REG_COLOR, {24'h0, bg_a, fg_a});
        en_frame = vs_count;
        chk_from = en_frame + 2;
        apb_write(REG_CTRL, 32'h1);
        repeat (BOUNCE_FRAMES) begin
            next_frame();
            check_position("bounce");
        end

        // swap colours in the middle of an active frame
        @(posedge de);
        repeat (H_TOTAL * 10) @(negedge clk_100m);
        fg_b      = bg_a;
        bg_b      = fg_a;
        col_frame = vs_count + 2;
        apb_write(REG_COLOR, {24'h0, bg_b, fg_b});
        repeat (COLOR_FRAMES) begin
            next_frame();
            check_position("colour change");
        end

        if (!(turn_r && turn_l && turn_b && turn_t)) begin
            fail_run("the square did not reverse at all four edges");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
